/* hw/commit_mon_config.svh */
`ifndef COMMIT_MON_CONFIG_SVH
`define COMMIT_MON_CONFIG_SVH

// retire lanes per cycle, 1 to 8
`define COMMIT_LANES 4

// retirement order number width
`define ORDER_W 64

// pc and instruction width
`define XLEN 32

// perf counter width
`define COUNT_W 32

`endif

/* hw/commit_mon_pkg.sv */
`default_nettype none

`include "commit_mon_config.svh"

package commit_mon_pkg;

    typedef logic [`ORDER_W-1:0] order_t;      // retirement order number
    typedef logic [`XLEN-1:0] word_t;          // insn or pc
    typedef logic [`COMMIT_LANES-1:0] lane_mask_t;
    typedef logic [`COUNT_W-1:0] count_t;

    // number of valid lanes in one cycle, 0 to COMMIT_LANES
    typedef logic [$clog2(`COMMIT_LANES + 1)-1:0] lane_cnt_t;

    typedef enum logic [1:0] {
        mark_none,
        mark_seg_start,
        mark_seg_stop
    } marker_e;

endpackage

`default_nettype wire

/* hw/commit_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_mon_config.svh"

module commit_capture import commit_mon_pkg::*; (
    input  logic                           itf,
    input  logic                           arst_n,
    input  lane_mask_t                     commit_valid,
    input  order_t  [`COMMIT_LANES-1:0]    commit_order,
    input  word_t   [`COMMIT_LANES-1:0]    commit_insn,
    input  word_t   [`COMMIT_LANES-1:0]    commit_pc_rdata,
    input  word_t   [`COMMIT_LANES-1:0]    commit_pc_wdata,
    output lane_mask_t                     cap_valid,
    output order_t  [`COMMIT_LANES-1:0]    cap_order,
    output lane_mask_t                     cap_halt,
    output marker_e [`COMMIT_LANES-1:0]    cap_marker
);

    localparam word_t INSN_BEQ_SELF = 32'h00000063;   // beq x0,x0,0
    localparam word_t INSN_JAL_SELF = 32'h0000006f;   // jal x0,0
    localparam word_t INSN_HALT_MARK = 32'hF0002013;
    localparam word_t INSN_SEG_START = 32'h00102013;
    localparam word_t INSN_SEG_STOP = 32'h00202013;

    lane_mask_t                  halt_d;
    marker_e [`COMMIT_LANES-1:0] marker_d;

    // per-lane decode, invalid lanes decode to nothing
    always_comb begin
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            halt_d[i] = commit_valid[i] &&
                        ((commit_pc_wdata[i] == commit_pc_rdata[i]) ||
                         (commit_insn[i] == INSN_BEQ_SELF) ||
                         (commit_insn[i] == INSN_JAL_SELF) ||
                         (commit_insn[i] == INSN_HALT_MARK));

            if (!commit_valid[i]) begin
                marker_d[i] = mark_none;
            end else if (commit_insn[i] == INSN_SEG_START) begin
                marker_d[i] = mark_seg_start;
            end else if (commit_insn[i] == INSN_SEG_STOP) begin
                marker_d[i] = mark_seg_stop;
            end else begin
                marker_d[i] = mark_none;
            end
        end
    end

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            cap_valid <= '0;
            cap_halt <= '0;
            for (int i = 0; i < `COMMIT_LANES; i++) begin
                cap_marker[i] <= mark_none;
            end
        end else begin
            cap_valid <= commit_valid;
            cap_halt <= halt_d;
            cap_marker <= marker_d;
        end
    end

    always_ff @(posedge itf) begin
        cap_order <= commit_order;
    end

endmodule

`default_nettype wire

/* hw/commit_order_check.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_mon_config.svh"

module commit_order_check import commit_mon_pkg::*; (
    input  logic                           itf,
    input  logic                           arst_n,
    input  lane_mask_t                     cap_valid,
    input  order_t  [`COMMIT_LANES-1:0]    cap_order,
    input  lane_mask_t                     cap_halt,
    input  marker_e [`COMMIT_LANES-1:0]    cap_marker,
    output lane_mask_t                     chk_valid,
    output lane_mask_t                     chk_halt,
    output marker_e [`COMMIT_LANES-1:0]    chk_marker,
    output logic                           error,
    output order_t                         error_order
);

    order_t    expected;       // order number due in lane 0
    order_t    expected_nxt;
    lane_cnt_t n_valid;
    lane_cnt_t n_above;        // valid lanes above the bad one
    logic      hole;
    logic      bad_found;
    order_t    bad_order;

    // a lane is bad if an invalid lane sits below it or its order is off
    always_comb begin
        n_valid = '0;
        n_above = '0;
        hole = 1'b0;
        bad_found = 1'b0;
        bad_order = '0;
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            if (cap_valid[i]) begin
                if (bad_found) begin
                    n_above = n_above + 1'b1;
                end else if (hole || (cap_order[i] != expected + order_t'(i))) begin
                    bad_found = 1'b1;
                    bad_order = cap_order[i];
                end
                n_valid = n_valid + 1'b1;
            end else begin
                hole = 1'b1;
            end
        end

        if (bad_found) begin
            expected_nxt = bad_order + order_t'(1) + order_t'(n_above);   // resync
        end else begin
            expected_nxt = expected + order_t'(n_valid);
        end
    end

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            expected <= '0;
            error <= 1'b0;
            error_order <= '0;
        end else begin
            expected <= expected_nxt;
            if (bad_found && !error) begin
                error <= 1'b1;
                error_order <= bad_order;   // first violation only
            end
        end
    end

    // keep lane info aligned with the perf stage
    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            chk_valid <= '0;
            chk_halt <= '0;
            for (int i = 0; i < `COMMIT_LANES; i++) begin
                chk_marker[i] <= mark_none;
            end
        end else begin
            chk_valid <= cap_valid;
            chk_halt <= cap_halt;
            chk_marker <= cap_marker;
        end
    end

endmodule

`default_nettype wire

/* hw/commit_perf_count.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_mon_config.svh"

module commit_perf_count import commit_mon_pkg::*; (
    input  logic                           itf,
    input  logic                           arst_n,
    input  lane_mask_t                     chk_valid,
    input  lane_mask_t                     chk_halt,
    input  marker_e [`COMMIT_LANES-1:0]    chk_marker,
    output logic                           halted,
    output count_t                         retired_total,
    output logic                           seg_done,
    output count_t                         seg_insts,
    output count_t                         seg_cycles
);

    count_t    ins_cnt;        // insns since last start
    count_t    cyc_cnt;        // cycles since last start
    lane_cnt_t n_valid;
    lane_cnt_t above_start;    // valid lanes above the start marker
    lane_cnt_t upto_stop;      // valid lanes up to and including stop
    lane_cnt_t in_seg;         // valid lanes in (start, stop]
    logic      start_hit;
    logic      stop_hit;
    logic      start_first;

    // only the first marker of each kind counts
    always_comb begin
        n_valid = '0;
        above_start = '0;
        upto_stop = '0;
        in_seg = '0;
        start_hit = 1'b0;
        stop_hit = 1'b0;
        start_first = 1'b0;
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            if (chk_valid[i]) begin
                n_valid = n_valid + 1'b1;
                if (start_hit) begin
                    above_start = above_start + 1'b1;
                end
                if (!stop_hit) begin
                    upto_stop = upto_stop + 1'b1;
                end
                if (start_hit && !stop_hit) begin
                    in_seg = in_seg + 1'b1;
                end
            end
            if (!start_hit && chk_marker[i] == mark_seg_start) begin
                start_hit = 1'b1;
                start_first = !stop_hit;
            end
            if (!stop_hit && chk_marker[i] == mark_seg_stop) begin
                stop_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
            retired_total <= '0;
        end else begin
            if (|(chk_halt & chk_valid)) begin
                halted <= 1'b1;   // sticky
            end
            retired_total <= retired_total + count_t'(n_valid);
        end
    end

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            ins_cnt <= '0;
            cyc_cnt <= '0;
            seg_done <= 1'b0;
            seg_insts <= '0;
            seg_cycles <= '0;
        end else begin
            seg_done <= stop_hit;
            if (stop_hit) begin
                if (start_hit && start_first) begin
                    // start and stop in the same cycle
                    seg_insts <= count_t'(in_seg);
                    seg_cycles <= '0;
                end else begin
                    seg_insts <= ins_cnt + count_t'(upto_stop);
                    seg_cycles <= cyc_cnt + count_t'(1);
                end
            end

            if (start_hit) begin
                ins_cnt <= count_t'(above_start);
                cyc_cnt <= '0;
            end else begin
                ins_cnt <= ins_cnt + count_t'(n_valid);
                cyc_cnt <= cyc_cnt + count_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/commit_mon_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_mon_config.svh"

module commit_mon_top import commit_mon_pkg::*; (
    input  logic                           itf,
    input  logic                           arst_n,
    input  lane_mask_t                     commit_valid,
    input  order_t  [`COMMIT_LANES-1:0]    commit_order,
    input  word_t   [`COMMIT_LANES-1:0]    commit_insn,
    input  word_t   [`COMMIT_LANES-1:0]    commit_pc_rdata,
    input  word_t   [`COMMIT_LANES-1:0]    commit_pc_wdata,
    output logic                           error,
    output order_t                         error_order,
    output logic                           halted,
    output count_t                         retired_total,
    output logic                           seg_done,
    output count_t                         seg_insts,
    output count_t                         seg_cycles
);

    lane_mask_t                  cap_valid;
    order_t  [`COMMIT_LANES-1:0] cap_order;
    lane_mask_t                  cap_halt;
    marker_e [`COMMIT_LANES-1:0] cap_marker;

    lane_mask_t                  chk_valid;
    lane_mask_t                  chk_halt;
    marker_e [`COMMIT_LANES-1:0] chk_marker;

    commit_capture u_capture (
        .itf             (itf),
        .arst_n          (arst_n),
        .commit_valid    (commit_valid),
        .commit_order    (commit_order),
        .commit_insn     (commit_insn),
        .commit_pc_rdata (commit_pc_rdata),
        .commit_pc_wdata (commit_pc_wdata),
        .cap_valid       (cap_valid),
        .cap_order       (cap_order),
        .cap_halt        (cap_halt),
        .cap_marker      (cap_marker)
    );

    commit_order_check u_order_check (
        .itf         (itf),
        .arst_n      (arst_n),
        .cap_valid   (cap_valid),
        .cap_order   (cap_order),
        .cap_halt    (cap_halt),
        .cap_marker  (cap_marker),
        .chk_valid   (chk_valid),
        .chk_halt    (chk_halt),
        .chk_marker  (chk_marker),
        .error       (error),
        .error_order (error_order)
    );

    commit_perf_count u_perf_count (
        .itf           (itf),
        .arst_n        (arst_n),
        .chk_valid     (chk_valid),
        .chk_halt      (chk_halt),
        .chk_marker    (chk_marker),
        .halted        (halted),
        .retired_total (retired_total),
        .seg_done      (seg_done),
        .seg_insts     (seg_insts),
        .seg_cycles    (seg_cycles)
    );

endmodule

`default_nettype wire

/* bench/commit_mon_vectors.svh */
`ifndef COMMIT_MON_VECTORS_SVH
`define COMMIT_MON_VECTORS_SVH

    task automatic load_rows();
        // columns: reset before row, lane mask, kinds (nibble per lane, lane 0 lowest),
        // lane 0 order, then error, error_order, halted, retired_total,
        // seg_done, seg_insts, seg_cycles expected once the row has passed through
        // kinds 0 filler, 1 seg start, 2 seg stop, 3 jal self, 4 pc_wdata equal to pc_rdata

        // packed commits with 1 to 4 lanes
        add_row(1, 4'b0001, 16'h0000,  0, 0,  0, 0,  1, 0, 0, 0);
        add_row(0, 4'b0011, 16'h0000,  1, 0,  0, 0,  3, 0, 0, 0);
        add_row(0, 4'b0111, 16'h0000,  3, 0,  0, 0,  6, 0, 0, 0);
        add_row(0, 4'b1111, 16'h0000,  6, 0,  0, 0, 10, 0, 0, 0);
        add_row(0, 4'b0000, 16'h0000, 10, 0,  0, 0, 10, 0, 0, 0);
        // start in lane 2, stop in lane 1 three rows later
        add_row(0, 4'b1111, 16'h0100, 10, 0,  0, 0, 14, 0, 0, 0);
        add_row(0, 4'b0011, 16'h0000, 14, 0,  0, 0, 16, 0, 0, 0);
        add_row(0, 4'b0111, 16'h0000, 16, 0,  0, 0, 19, 0, 0, 0);
        add_row(0, 4'b1111, 16'h0020, 19, 0,  0, 0, 23, 1, 8, 3);
        add_row(0, 4'b0001, 16'h0000, 23, 0,  0, 0, 24, 0, 8, 3);
        // gap, 24 due but 30 arrives
        add_row(0, 4'b0011, 16'h0000, 30, 1, 30, 0, 26, 0, 8, 3);
        add_row(0, 4'b0011, 16'h0000, 32, 1, 30, 0, 28, 0, 8, 3);
        add_row(0, 4'b0111, 16'h0000, 34, 1, 30, 0, 31, 0, 8, 3);

        // hole in lane 2 after a fresh reset, then a pc halt
        add_row(1, 4'b0011, 16'h0000,  0, 0,  0, 0,  2, 0, 0, 0);
        add_row(0, 4'b1011, 16'h0000,  2, 1,  5, 0,  5, 0, 0, 0);
        add_row(0, 4'b0001, 16'h0000,  6, 1,  5, 0,  6, 0, 0, 0);
        add_row(0, 4'b0011, 16'h0040,  7, 1,  5, 1,  8, 0, 0, 0);
        add_row(0, 4'b0001, 16'h0000,  9, 1,  5, 1,  9, 0, 0, 0);

        // jal halt on its own after another reset
        add_row(1, 4'b0001, 16'h0003,  0, 0,  0, 1,  1, 0, 0, 0);
        add_row(0, 4'b0001, 16'h0000,  1, 0,  0, 1,  2, 0, 0, 0);
    endtask

`endif

/* bench/commit_mon_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_mon_config.svh"

module commit_mon_tb import commit_mon_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int LANES = `COMMIT_LANES;
    localparam logic [3:0] KIND_START = 4'd1;
    localparam logic [3:0] KIND_STOP = 4'd2;
    localparam logic [3:0] KIND_JAL = 4'd3;
    localparam logic [3:0] KIND_PC_HALT = 4'd4;

    logic               itf = 1'b0;
    logic               arst_n;
    lane_mask_t         commit_valid;
    order_t [LANES-1:0] commit_order;
    word_t  [LANES-1:0] commit_insn;
    word_t  [LANES-1:0] commit_pc_rdata;
    word_t  [LANES-1:0] commit_pc_wdata;
    logic               error;
    order_t             error_order;
    logic               halted;
    count_t             retired_total;
    logic               seg_done;
    count_t             seg_insts;
    count_t             seg_cycles;

    bit          row_first[$];      // reset before this row
    lane_mask_t  row_mask[$];
    logic [15:0] row_kinds[$];
    order_t      row_base[$];
    logic        exp_error[$];
    order_t      exp_error_order[$];
    logic        exp_halted[$];
    count_t      exp_total[$];
    logic        exp_seg_done[$];
    count_t      exp_seg_insts[$];
    count_t      exp_seg_cycles[$];

    logic [31:0] lfsr_state = 32'd99843;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    always #4 itf = ~itf;

    commit_mon_top UUT (
        .itf             (itf),
        .arst_n          (arst_n),
        .commit_valid    (commit_valid),
        .commit_order    (commit_order),
        .commit_insn     (commit_insn),
        .commit_pc_rdata (commit_pc_rdata),
        .commit_pc_wdata (commit_pc_wdata),
        .error           (error),
        .error_order     (error_order),
        .halted          (halted),
        .retired_total   (retired_total),
        .seg_done        (seg_done),
        .seg_insts       (seg_insts),
        .seg_cycles      (seg_cycles)
    );

    task automatic add_row(input bit first, input lane_mask_t mask, input logic [15:0] kinds,
                           input order_t base, input logic err, input order_t err_order,
                           input logic halt, input count_t total, input logic done,
                           input count_t insts, input count_t cycles);
        row_first.push_back(first);
        row_mask.push_back(mask);
        row_kinds.push_back(kinds);
        row_base.push_back(base);
        exp_error.push_back(err);
        exp_error_order.push_back(err_order);
        exp_halted.push_back(halt);
        exp_total.push_back(total);
        exp_seg_done.push_back(done);
        exp_seg_insts.push_back(insts);
        exp_seg_cycles.push_back(cycles);
    endtask

`include "commit_mon_vectors.svh"

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t w;
        w = '0;
        for (int b = 0; b < n; b++) begin
            w[b] = lfsr_bit();
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h, expected %h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // idx below 0 drives an idle cycle
    task automatic drive_row(input int idx);
        logic [3:0] kind;
        word_t      pc;
        word_t      filler;
        commit_valid = '0;
        for (int i = 0; i < LANES; i++) begin
            kind = 4'd0;
            commit_order[i] = order_t'(i);
            if (idx >= 0) begin
                kind = row_kinds[idx][4*i +: 4];
                commit_order[i] = row_base[idx] + order_t'(i);
            end
            pc = rand_bits(30) << 2;
            filler = (rand_bits(25) << 7) | 32'h0000_0033;   // R-type opcode
            case (kind)
                KIND_START: commit_insn[i] = 32'h00102013;
                KIND_STOP: commit_insn[i] = 32'h00202013;
                KIND_JAL: commit_insn[i] = 32'h0000006f;
                default: commit_insn[i] = filler;
            endcase
            commit_pc_rdata[i] = pc;
            commit_pc_wdata[i] = (kind == KIND_PC_HALT) ? pc : pc + 32'd4;
        end
        if (idx >= 0) begin
            commit_valid = row_mask[idx];
        end
    endtask

    task automatic expect_order_outputs(input int idx);
        check_value("error", error, exp_error[idx]);
        check_value("error_order", error_order, exp_error_order[idx]);
    endtask

    task automatic expect_perf_outputs(input int idx);
        check_value("halted", halted, exp_halted[idx]);
        check_value("retired_total", retired_total, exp_total[idx]);
        check_value("seg_done", seg_done, exp_seg_done[idx]);
        check_value("seg_insts", seg_insts, exp_seg_insts[idx]);
        check_value("seg_cycles", seg_cycles, exp_seg_cycles[idx]);
    endtask

    task automatic apply_reset();
        @(negedge itf);
        arst_n = 1'b0;
        drive_row(-1);
        repeat (RESET_CYCLES) @(negedge itf);
        arst_n = 1'b1;
        check_value("error", error, 0);
        check_value("halted", halted, 0);
        check_value("seg_done", seg_done, 0);
        check_value("retired_total", retired_total, 0);
    endtask

    // error lags a row by two edges, perf outputs by three
    task automatic run_section(input int lo, input int hi);
        for (int m = 0; m <= hi - lo + 3; m++) begin
            @(negedge itf);
            drive_row((lo + m <= hi) ? lo + m : -1);
            if (m >= 2 && m - 2 <= hi - lo) begin
                expect_order_outputs(lo + m - 2);
            end
            if (m >= 3) begin
                expect_perf_outputs(lo + m - 3);
            end
        end
    endtask

    always @(posedge itf) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int lo;
        int hi;
        int sections;
        arst_n = 1'b0;
        drive_row(-1);
        load_rows();
        sections = 0;
        foreach (row_first[r]) begin
            if (row_first[r]) begin
                sections++;
            end
        end
        cycle_limit = row_first.size() + sections * (RESET_CYCLES + 4) + 16;

        lo = 0;
        while (lo < row_first.size()) begin
            hi = lo;
            while (hi + 1 < row_first.size() && !row_first[hi + 1]) begin
                hi++;
            end
            apply_reset();
            run_section(lo, hi);
            lo = hi + 1;
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* commit_mon.f */
+incdir+hw
+incdir+bench
hw/commit_mon_pkg.sv
hw/commit_capture.sv
hw/commit_order_check.sv
hw/commit_perf_count.sv
hw/commit_mon_top.sv
bench/commit_mon_tb.sv
